//--- rtl/capture_pkg.sv
package capture_pkg;

    // sample and word geometry
    localparam int SAMPLE_W         = 12;
    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;
    localparam int BYTE_W           = 8;

    // buffer depths as log2 of entry count
    localparam int SAMPLE_DEPTH_LOG2 = 10;  // 1024 samples
    localparam int WORD_DEPTH_LOG2   = 9;   // 512 words

    localparam int COUNT_W = 16;
    localparam int DECIM_W = 13;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [COUNT_W-1:0]  count_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_e;

endpackage

//--- rtl/fifo_if.sv
`timescale 1ns/1ns

interface fifo_if #(
    parameter int W = 8
);

    logic         wr;
    logic [W-1:0] wdata;
    logic         full;
    logic         rd;
    logic [W-1:0] rdata;    // oldest entry, valid while empty is low
    logic         empty;

    modport producer (output wr, output wdata, input full);

    modport consumer (output rd, input rdata, input empty);

    modport store (
        input  wr,
        input  wdata,
        input  rd,
        output full,
        output rdata,
        output empty
    );

endinterface

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic  adc_sampleclk,
    input  logic  reset,
    input  logic  flush_i,
    output logic  err_o,
    fifo_if.store bus
);

    localparam int W = $bits(bus.wdata);

    logic [W-1:0]        mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2:0] wr_ptr;    // extra msb tells full from empty
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign bus.empty = (wr_ptr == rd_ptr);
    assign bus.full  = (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]) &&
                       (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

    // show-ahead read port
    assign bus.rdata = mem[rd_ptr[DEPTH_LOG2-1:0]];

    assign do_wr = bus.wr && !bus.full;
    assign do_rd = bus.rd && !bus.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            err_o  <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            // overflow or underflow, one pulse per bad access
            err_o <= (bus.wr && bus.full) || (bus.rd && bus.empty);
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= bus.wdata;
    end

endmodule

//--- rtl/capture_ctrl.sv
`timescale 1ns/1ns

module capture_ctrl (
    input  logic                            adc_sampleclk,
    input  logic                            reset,
    input  logic                            arm_i,
    input  logic                            capture_go_i,
    input  capture_pkg::sample_t            adc_data_i,
    input  logic [capture_pkg::DECIM_W-1:0] decim_i,
    input  capture_pkg::count_t             presample_i,
    input  capture_pkg::count_t             max_samples_i,
    input  logic                            sample_err_i,
    input  logic                            word_err_i,
    output logic                            capture_done_o,
    output logic                            error_o,
    output logic                            flush_o,
    output logic                            discard_o,
    output logic                            forward_o,
    fifo_if.producer                        sample_bus
);

    capture_pkg::capture_state_e     state;
    logic                            arm_r;
    logic                            armed;     // set once an arm has been seen
    logic [capture_pkg::DECIM_W-1:0] decim_ctr;
    capture_pkg::count_t             sample_cnt;
    capture_pkg::count_t             cnt_next;
    logic                            tick;
    logic                            trig;
    logic                            take;
    logic                            count_en;
    logic                            last_sample;

    // flush follows the arm rising edge by one cycle
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r   <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            arm_r   <= arm_i;
            flush_o <= arm_i && !arm_r;
        end
    end

    // keep one sample out of every decim_i+1
    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_o)
            decim_ctr <= '0;
        else if (decim_ctr >= decim_i)
            decim_ctr <= '0;
        else
            decim_ctr <= decim_ctr + 1'b1;
    end

    assign tick = (decim_ctr == '0) && !flush_o;

    // trigger only counts while waiting for it
    assign trig = capture_go_i &&
                  (state inside {capture_pkg::PRESAMP_FILLING, capture_pkg::PRESAMP_FULL} ||
                   (state == capture_pkg::IDLE && armed));

    assign take = tick && (trig || state inside {capture_pkg::PRESAMP_FILLING,
                                                 capture_pkg::PRESAMP_FULL,
                                                 capture_pkg::TRIGGERED});

    // presample window full, drop the oldest for each new one
    assign discard_o   = take && (state == capture_pkg::PRESAMP_FULL) && !trig;
    assign count_en    = take && !discard_o;
    assign cnt_next    = sample_cnt + 1'b1;
    assign last_sample = count_en && (cnt_next == max_samples_i);

    assign sample_bus.wr    = take;
    assign sample_bus.wdata = adc_data_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state      <= capture_pkg::IDLE;
            armed      <= 1'b0;
            sample_cnt <= '0;
            forward_o  <= 1'b0;
        end else if (flush_o) begin
            state      <= (presample_i == '0) ? capture_pkg::IDLE : capture_pkg::PRESAMP_FILLING;
            armed      <= 1'b1;
            sample_cnt <= '0;
            forward_o  <= 1'b0;
        end else begin
            if (count_en)
                sample_cnt <= cnt_next;
            if (trig)
                forward_o <= 1'b1;  // held until the next flush
            case (state)
                capture_pkg::IDLE,
                capture_pkg::PRESAMP_FILLING,
                capture_pkg::PRESAMP_FULL: begin
                    if (trig)
                        state <= last_sample ? capture_pkg::DONE : capture_pkg::TRIGGERED;
                    else if (state == capture_pkg::PRESAMP_FILLING && count_en &&
                             cnt_next == presample_i)
                        state <= capture_pkg::PRESAMP_FULL;
                end
                capture_pkg::TRIGGERED: begin
                    if (last_sample)
                        state <= capture_pkg::DONE;
                end
                default: ;  // DONE waits for the next arm
            endcase
        end
    end

    assign capture_done_o = (state == capture_pkg::DONE);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_o)
            error_o <= 1'b0;
        else if (sample_err_i || word_err_i)
            error_o <= 1'b1;
    end

    // whole words only, and the window must fit inside the capture
    a_arm_counts: assert property (@(posedge adc_sampleclk) disable iff (reset)
        flush_o |-> (max_samples_i % capture_pkg::SAMPLES_PER_WORD == 0) &&
                    (max_samples_i >= presample_i));

    // a write into a full sample FIFO must reach the error flag
    a_overflow_flagged: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (take && sample_bus.full) ##1 !flush_o |=> error_o);

endmodule

//--- rtl/word_packer.sv
`timescale 1ns/1ns

module word_packer (
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  logic     flush_i,
    input  logic     discard_i,
    input  logic     forward_i,
    fifo_if.consumer sample_bus,
    fifo_if.producer word_bus
);

    localparam logic [1:0] LAST_SLOT = 2'(capture_pkg::SAMPLES_PER_WORD - 1);

    logic [1:0]          slot;
    logic                shift;
    logic                wr_r;
    capture_pkg::word_t  word_r;

    // move a sample only when the word FIFO can take the result
    assign shift = forward_i && !discard_i && !flush_i &&
                   !sample_bus.empty && !word_bus.full;

    assign sample_bus.rd = discard_i || shift;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            slot <= '0;
            wr_r <= 1'b0;
        end else begin
            wr_r <= shift && (slot == LAST_SLOT);   // word complete
            if (shift)
                slot <= (slot == LAST_SLOT) ? 2'd0 : slot + 2'd1;
        end
    end

    // earliest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (shift)
            word_r <= {word_r[capture_pkg::WORD_W-capture_pkg::SAMPLE_W-1:0], sample_bus.rdata};
    end

    assign word_bus.wr    = wr_r;
    assign word_bus.wdata = word_r;

    a_discard_nonempty: assert property (@(posedge adc_sampleclk) disable iff (reset)
        discard_i |-> !sample_bus.empty);

endmodule

//--- rtl/byte_readout.sv
`timescale 1ns/1ns

module byte_readout (
    input  logic                           adc_sampleclk,
    input  logic                           reset,
    input  logic                           flush_i,
    input  logic                           low_res_i,
    input  logic                           read_en_i,
    output logic [capture_pkg::BYTE_W-1:0] read_data_o,
    output logic                           read_empty_o,
    fifo_if.consumer                       word_bus
);

    logic [3:0]         idx;    // 0..2 low res, 0..8 high res
    logic [3:0]         rem_r;  // low nibble of the first word in a pair
    logic               wrap;
    logic               last_byte;
    logic               step;
    capture_pkg::word_t w;

    assign w = word_bus.rdata;

    assign wrap      = low_res_i ? (idx == 4'd2) : (idx == 4'd8);
    assign last_byte = wrap || (!low_res_i && idx == 4'd3);
    assign step      = read_en_i && !word_bus.empty && !flush_i;

    // reads while empty go on to the FIFO so the underflow is flagged
    assign word_bus.rd  = read_en_i && !flush_i && (word_bus.empty || last_byte);
    assign read_empty_o = word_bus.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i)
            idx <= '0;
        else if (step)
            idx <= wrap ? 4'd0 : idx + 4'd1;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (step && !low_res_i && idx == 4'd3)
            rem_r <= w[3:0];
    end

    always_comb begin
        if (low_res_i) begin
            case (idx)
                4'd0:    read_data_o = w[35:28];    // upper 8 of each sample
                4'd1:    read_data_o = w[23:16];
                4'd2:    read_data_o = w[11:4];
                default: read_data_o = '0;
            endcase
        end else begin
            // two words give 72 bits, 9 bytes
            case (idx)
                4'd0:    read_data_o = w[35:28];
                4'd1:    read_data_o = w[27:20];
                4'd2:    read_data_o = w[19:12];
                4'd3:    read_data_o = w[11:4];
                4'd4:    read_data_o = {rem_r, w[35:32]};
                4'd5:    read_data_o = w[31:24];
                4'd6:    read_data_o = w[23:16];
                4'd7:    read_data_o = w[15:8];
                4'd8:    read_data_o = w[7:0];
                default: read_data_o = '0;
            endcase
        end
    end

endmodule

//--- rtl/adc_capture_top.sv
`timescale 1ns/1ns

module adc_capture_top (
    input  logic                            adc_sampleclk,
    input  logic                            reset,
    input  capture_pkg::sample_t            adc_data_i,
    input  logic                            arm_i,
    input  logic                            capture_go_i,
    input  logic [capture_pkg::DECIM_W-1:0] decim_i,
    input  capture_pkg::count_t             presample_i,
    input  capture_pkg::count_t             max_samples_i,
    input  logic                            low_res_i,
    input  logic                            read_en_i,
    output logic [capture_pkg::BYTE_W-1:0]  read_data_o,
    output logic                            read_empty_o,
    output logic                            capture_done_o,
    output logic                            error_o
);

    logic flush;
    logic discard;
    logic forward;
    logic sample_err;
    logic word_err;

    fifo_if #(.W($bits(capture_pkg::sample_t))) sample_bus ();
    fifo_if #(.W($bits(capture_pkg::word_t)))   word_bus ();

    capture_ctrl u_ctrl (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .adc_data_i     (adc_data_i),
        .decim_i        (decim_i),
        .presample_i    (presample_i),
        .max_samples_i  (max_samples_i),
        .sample_err_i   (sample_err),
        .word_err_i     (word_err),
        .capture_done_o (capture_done_o),
        .error_o        (error_o),
        .flush_o        (flush),
        .discard_o      (discard),
        .forward_o      (forward),
        .sample_bus     (sample_bus.producer)
    );

    sync_fifo #(.DEPTH_LOG2(capture_pkg::SAMPLE_DEPTH_LOG2)) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .err_o         (sample_err),
        .bus           (sample_bus.store)
    );

    word_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .discard_i     (discard),
        .forward_i     (forward),
        .sample_bus    (sample_bus.consumer),
        .word_bus      (word_bus.producer)
    );

    sync_fifo #(.DEPTH_LOG2(capture_pkg::WORD_DEPTH_LOG2)) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .err_o         (word_err),
        .bus           (word_bus.store)
    );

    byte_readout u_readout (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .low_res_i     (low_res_i),
        .read_en_i     (read_en_i),
        .read_data_o   (read_data_o),
        .read_empty_o  (read_empty_o),
        .word_bus      (word_bus.consumer)
    );

endmodule

//--- include/tb_capture_model.svh
`ifndef TB_CAPTURE_MODEL_SVH
`define TB_CAPTURE_MODEL_SVH

// model of the sample FIFO contents and of the byte stream they give
capture_pkg::sample_t kept_samples[$];
byte unsigned         exp_bytes[$];

function automatic void clear_model();
    kept_samples.delete();
    exp_bytes.delete();
endfunction

function automatic void add_sample(capture_pkg::sample_t s);
    kept_samples.push_back(s);
endfunction

// presample window dropped its oldest entry
function automatic void discard_oldest();
    if (kept_samples.size() > 0)
        void'(kept_samples.pop_front());
endfunction

// low res keeps the top byte while high res cuts the 12-bit stream into bytes
function automatic void build_bytes(bit low_res);
    logic [23:0] acc;
    int          nbits;
    acc   = '0;
    nbits = 0;
    exp_bytes.delete();
    foreach (kept_samples[i]) begin
        if (low_res) begin
            exp_bytes.push_back(kept_samples[i][11:4]);
        end else begin
            acc   = {acc[11:0], kept_samples[i]};
            nbits = nbits + capture_pkg::SAMPLE_W;
            while (nbits >= capture_pkg::BYTE_W) begin
                exp_bytes.push_back(8'(acc >> (nbits - capture_pkg::BYTE_W)));
                nbits = nbits - capture_pkg::BYTE_W;
            end
        end
    end
endfunction

`endif

//--- verif/tb_adc_capture.sv
`timescale 1ns/1ns

module tb_adc_capture;

    `include "tb_capture_model.svh"

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_SAMPLES = 162;   // largest random capture
    localparam int MAX_STRIDE  = 7;     // decimation up to 6
    localparam int READ_STRIDE = 3;     // strobe plus up to two idle cycles
    localparam int TEST_CYCLES = MAX_SAMPLES * (MAX_STRIDE + 2 * READ_STRIDE) + 500;
    localparam int OVF_SAMPLES = 3000;  // more than both FIFOs can hold
    localparam int WATCHDOG_CYCLES = 16 + 5 * TEST_CYCLES + OVF_SAMPLES + 500;

    logic                            adc_sampleclk = 1'b0;
    logic                            reset;
    capture_pkg::sample_t            adc_data_i;
    logic                            arm_i;
    logic                            capture_go_i;
    logic [capture_pkg::DECIM_W-1:0] decim_i;
    capture_pkg::count_t             presample_i;
    capture_pkg::count_t             max_samples_i;
    logic                            low_res_i;
    logic                            read_en_i;
    logic [capture_pkg::BYTE_W-1:0]  read_data_o;
    logic                            read_empty_o;
    logic                            capture_done_o;
    logic                            error_o;

    logic [31:0]     rng;
    logic [7:0]      got[$];    // bytes from the read port
    logic [11:0]     caps[$];   // samples rebuilt from high res bytes
    string           test_name;
    int              errors;
    int              d;
    int              pre;
    int              max_s;
    int              below;

    // model state updated on every clock edge
    bit arm_prev;
    bit flush_due;
    bit waiting;
    bit capturing;
    bit tick;
    int phase;
    int kept;
    int trig_val;

    adc_capture_top dut (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data_i     (adc_data_i),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .decim_i        (decim_i),
        .presample_i    (presample_i),
        .max_samples_i  (max_samples_i),
        .low_res_i      (low_res_i),
        .read_en_i      (read_en_i),
        .read_data_o    (read_data_o),
        .read_empty_o   (read_empty_o),
        .capture_done_o (capture_done_o),
        .error_o        (error_o)
    );

    always #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;

    // counter standing in for the ADC so each value names its cycle
    always @(posedge adc_sampleclk) begin
        #1;
        adc_data_i = adc_data_i + 1'b1;
    end

    // which input values end up in the buffer
    always @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_prev  = 1'b0;
            flush_due = 1'b0;
            waiting   = 1'b0;
            capturing = 1'b0;
            phase     = 0;
        end else begin
            if (flush_due) begin
                phase     = 0;
                waiting   = 1'b1;
                capturing = 1'b0;
                kept      = 0;
                clear_model();
            end else begin
                tick  = (phase == 0);
                phase = (phase >= decim_i) ? 0 : phase + 1;
                if (waiting && capture_go_i) begin
                    waiting   = 1'b0;
                    capturing = 1'b1;
                    trig_val  = adc_data_i;
                end else if (waiting && tick && presample_i != 0) begin
                    add_sample(adc_data_i);
                    if (kept == presample_i)
                        discard_oldest();    // window full
                    else
                        kept++;
                end
                if (capturing && tick) begin
                    add_sample(adc_data_i);
                    kept++;
                    if (kept == max_samples_i)
                        capturing = 1'b0;
                end
            end
            flush_due = arm_i && !arm_prev;
            arm_prev  = arm_i;
        end
    end

    function automatic int unsigned next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
        else abort_run($sformatf("** Error %s %s: expected %0d, actual %0d",
                                 test_name, what, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #1;
    endtask

    task automatic start_capture(input int dec, input int pres, input int maxs, input bit lo);
        decim_i       = 13'(dec);
        presample_i   = 16'(pres);
        max_samples_i = 16'(maxs);
        low_res_i     = lo;
        arm_i         = 1'b1;
        next_cycle();
        arm_i = 1'b0;
        next_cycle();   // flush edge
    endtask

    task automatic fire_trigger(input int delay);
        repeat (delay) next_cycle();
        capture_go_i = 1'b1;
        next_cycle();
        capture_go_i = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (!capture_done_o) begin
            next_cycle();
            waited++;
            assert (waited <= limit)
            else abort_run("capture_done_o did not rise before the timeout");
        end
    endtask

    // one strobe per byte with random gaps
    task automatic read_bytes(input int n);
        int idle;
        got.delete();
        while (got.size() < n) begin
            idle = 0;
            while (read_empty_o) begin
                next_cycle();
                idle++;
                assert (idle < 20000) else abort_run("read port stayed empty too long");
            end
            got.push_back(read_data_o);
            read_en_i = 1'b1;
            next_cycle();
            read_en_i = 1'b0;
            repeat (next_rand() % 3) next_cycle();
        end
    endtask

    // three bytes carry two samples
    function automatic void unpack_samples();
        caps.delete();
        for (int k = 0; k + 2 < got.size(); k += 3) begin
            caps.push_back({got[k], got[k+1][7:4]});
            caps.push_back({got[k+1][3:0], got[k+2]});
        end
    endfunction

    task automatic compare_with_model(input bit lo);
        build_bytes(lo);
        check_value("byte count", exp_bytes.size(), got.size());
        foreach (got[i])
            check_value($sformatf("byte %0d", i), exp_bytes[i], got[i]);
    endtask

    // no data may follow the expected bytes
    task automatic check_drained();
        assert (read_empty_o) else abort_run("read_empty_o stayed low after the last byte");
    endtask

    task automatic check_clean();
        assert (!error_o) else abort_run("error_o set although reading kept up");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        rng           = 32'hfb72;
        errors        = 0;
        reset         = 1'b1;
        adc_data_i    = '0;
        arm_i         = 1'b0;
        capture_go_i  = 1'b0;
        decim_i       = '0;
        presample_i   = '0;
        max_samples_i = '0;
        low_res_i     = 1'b1;
        read_en_i     = 1'b0;
        repeat (16) next_cycle();
        reset = 1'b0;
        next_cycle();

        test_name = "no_presamples";
        max_s = 3 * (1 + next_rand() % 40);
        start_capture(0, 0, max_s, 1'b1);
        fire_trigger(next_rand() % 16);
        read_bytes(max_s);
        wait_done(1000);
        check_drained();
        foreach (got[i])
            check_value($sformatf("byte %0d", i), 8'(((trig_val + i) % 4096) >> 4), got[i]);
        compare_with_model(1'b1);
        check_clean();

        test_name = "decimation";
        d     = 1 + next_rand() % 6;
        max_s = 6 * (1 + next_rand() % 20);
        start_capture(d, 0, max_s, 1'b0);
        fire_trigger(next_rand() % 20);
        read_bytes(max_s * 3 / 2);
        wait_done(1000);
        check_drained();
        unpack_samples();
        for (int i = 1; i < caps.size(); i++)
            check_value($sformatf("step %0d", i), d + 1, 12'(caps[i] - caps[i-1]));
        compare_with_model(1'b0);
        check_clean();

        test_name = "presamples";
        pre   = 1 + next_rand() % 100;
        max_s = 6 * (pre / 6 + 1 + next_rand() % 8);
        start_capture(0, pre, max_s, 1'b0);
        fire_trigger(pre + 50 + next_rand() % 200);    // window long since full
        read_bytes(max_s * 3 / 2);
        wait_done(1000);
        check_drained();
        unpack_samples();
        below = 0;
        foreach (caps[i])
            if (12'(caps[i] - trig_val) >= 2048)
                below++;
        check_value("samples before trigger", pre, below);
        compare_with_model(1'b0);
        check_clean();

        test_name = "high_resolution";
        d     = next_rand() % 3;
        pre   = next_rand() % 30;
        max_s = 6 * (pre / 6 + 1 + next_rand() % 10);
        start_capture(d, pre, max_s, 1'b0);
        fire_trigger(pre * (d + 1) + next_rand() % 40);
        read_bytes(max_s * 3 / 2);
        wait_done(1000);
        compare_with_model(1'b0);
        check_drained();
        check_clean();

        test_name = "done_and_error";
        assert (capture_done_o) else abort_run("capture_done_o low after a finished capture");
        start_capture(0, 0, OVF_SAMPLES, 1'b1);
        assert (!capture_done_o) else abort_run("capture_done_o still high after a new arm");
        assert (!error_o) else abort_run("error_o set right after a new arm");
        fire_trigger(2);
        wait_done(OVF_SAMPLES + 100);   // nothing is read so both FIFOs overflow
        assert (error_o) else abort_run("error_o stayed low after the FIFOs overflowed");

        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "checks reported errors");
        end
    end

endmodule

//--- build.f
+incdir+include
rtl/capture_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/capture_ctrl.sv
rtl/word_packer.sv
rtl/byte_readout.sv
rtl/adc_capture_top.sv
verif/tb_adc_capture.sv
